// File: Makefile
# Verilator flow for the rename stage testbench

TOP := tb_rename_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f build.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "simulation ended without a pass line"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: branch_recovery.sv
`timescale 1ns/1ps
// ======================================
// branch resolution, oldest slot first
// a resolve with no held slot is ignored
// a mispredict releases every slot
// ======================================
`include "rename_defines.svh"

module branch_recovery (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           resolve_valid_i,
    input  logic                                           mispredict_i,
    input  logic [`RN_CP_SLOTS-1:0]                        slot_held_i,
    input  rename_types_pkg::map_image_t [`RN_CP_SLOTS-1:0] slot_image_i,
    input  rename_types_pkg::fl_ptr_t [`RN_CP_SLOTS-1:0]    slot_head_i,
    output logic [`RN_CP_SLOTS-1:0]                        release_o,
    output logic                                           restore_valid_o,
    output rename_types_pkg::map_image_t                   restore_image_o,
    output rename_types_pkg::fl_ptr_t                      restore_head_o
);

    // oldest held slot, follows the allocation pointer around the ring
    rename_ctrl_pkg::cp_idx_t oldest_q;

    logic oldest_held;
    logic resolve_ok;
    logic resolve_bad;

    assign oldest_held = slot_held_i[oldest_q];
    assign resolve_ok  = resolve_valid_i & ~mispredict_i & oldest_held;
    assign resolve_bad = resolve_valid_i & mispredict_i & oldest_held;

    // release strobes
    always_comb begin
        for (int s = 0; s < `RN_CP_SLOTS; s++) begin
            release_o[s] = resolve_bad
                         | (resolve_ok & (oldest_q == rename_ctrl_pkg::cp_idx_t'(s)));
        end
    end

    // restore source is always the oldest slot
    assign restore_valid_o = resolve_bad;
    assign restore_image_o = slot_image_i[oldest_q];
    assign restore_head_o  = slot_head_i[oldest_q];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            oldest_q <= '0;
        end else if (resolve_bad) begin
            // map table resets its allocation pointer in the same cycle
            oldest_q <= '0;
        end else if (resolve_ok) begin
            oldest_q <= oldest_q + 1'b1;
        end
    end

endmodule

// File: build.f
+incdir+.
rename_types_pkg.sv
rename_ctrl_pkg.sv
free_list.sv
map_table.sv
checkpoint_slot.sv
branch_recovery.sv
rename_unit.sv
rename_checker.sv
tb_rename_unit.sv

// File: checkpoint_slot.sv
`timescale 1ns/1ps
// ======================================
// one branch checkpoint
// saved image and head are only meaningful
// while the slot is held
// ======================================

module checkpoint_slot (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         capture_i,
    input  logic                         release_i,
    input  rename_types_pkg::map_image_t image_i,
    input  rename_types_pkg::fl_ptr_t    head_i,
    output logic                         held_o,
    output rename_types_pkg::map_image_t image_o,
    output rename_types_pkg::fl_ptr_t    head_o
);

    rename_ctrl_pkg::cp_state_e   state_q;
    rename_types_pkg::map_image_t image_q;
    rename_types_pkg::fl_ptr_t    head_q;

    // held/free state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q <= rename_ctrl_pkg::CP_FREE;
        end else if (capture_i) begin
            state_q <= rename_ctrl_pkg::CP_HELD;
        end else if (release_i) begin
            state_q <= rename_ctrl_pkg::CP_FREE;
        end
    end

    // saved copy
    always_ff @(posedge clock) begin
        if (capture_i) begin
            image_q <= image_i;
            head_q  <= head_i;
        end
    end

    assign held_o  = (state_q == rename_ctrl_pkg::CP_HELD);
    assign image_o = image_q;
    assign head_o  = head_q;

endmodule

// File: free_list.sv
`timescale 1ns/1ps
// ======================================
// circular queue of free physical tags
// holds tags ARCH..PHYS-1 after reset
// no overflow check since at most PHYS-ARCH
// tags are ever free at once
// pop and restore never share a cycle
// ======================================
`include "rename_defines.svh"

module free_list (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        pop_i,
    input  logic                        push_i,
    input  rename_types_pkg::phys_tag_t push_tag_i,
    input  logic                        restore_i,
    input  rename_types_pkg::fl_ptr_t   restore_head_i,
    output rename_types_pkg::phys_tag_t head_tag_o,
    output rename_types_pkg::fl_ptr_t   head_ptr_o,
    output logic                        empty_o
);

    localparam int IDX_W = $clog2(`RN_PHYS_REGS);

    // tag storage, one slot per physical tag
    rename_types_pkg::phys_tag_t mem_q [`RN_PHYS_REGS];
    rename_types_pkg::fl_ptr_t   head_q;
    rename_types_pkg::fl_ptr_t   tail_q;

    // ========================================
    // read side
    // ========================================
    assign head_tag_o = mem_q[head_q[IDX_W-1:0]];
    assign head_ptr_o = head_q;
    // equal pointers with equal wrap bits means nothing left
    assign empty_o    = (head_q == tail_q);

    // ========================================
    // pointer and storage update
    // ========================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // low half gets ARCH..PHYS-1, the rest is never read before a push
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                mem_q[i] <= rename_types_pkg::phys_tag_t'(i + `RN_ARCH_REGS);
            end
            head_q <= '0;
            tail_q <= rename_types_pkg::fl_ptr_t'(`RN_PHYS_REGS - `RN_ARCH_REGS);
        end else begin
            // commit frees land at the tail in every cycle, restore included
            if (push_i) begin
                mem_q[tail_q[IDX_W-1:0]] <= push_tag_i;
                tail_q                   <= tail_q + 1'b1;
            end
            // wrong-path tags between the saved head and the current head
            // are still in the queue so moving the head back frees them
            if (restore_i) begin
                head_q <= restore_head_i;
            end else if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

endmodule

// File: map_table.sv
`timescale 1ns/1ps
// ======================================
// register alias table, one rename per cycle
// ready state is kept per physical tag
// r0 is pinned to tag 0 and always ready
// branches take a checkpoint and no tag
// ======================================
`include "rename_defines.svh"

module map_table (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           disp_valid_i,
    input  logic                                           disp_branch_i,
    input  rename_types_pkg::arch_idx_t                    disp_arch_i,
    input  rename_types_pkg::arch_idx_t                    rs1_arch_i,
    input  rename_types_pkg::arch_idx_t                    rs2_arch_i,
    input  logic [`RN_WB_PORTS-1:0]                        wb_valid_i,
    input  rename_types_pkg::phys_tag_t [`RN_WB_PORTS-1:0] wb_phys_i,
    input  rename_types_pkg::phys_tag_t                    fl_head_tag_i,
    input  logic                                           fl_empty_i,
    input  logic [`RN_CP_SLOTS-1:0]                        cp_held_i,
    input  logic                                           restore_valid_i,
    input  rename_types_pkg::map_image_t                   restore_image_i,
    output rename_types_pkg::phys_tag_t                    rs1_phys_o,
    output rename_types_pkg::phys_tag_t                    rs2_phys_o,
    output logic                                           rs1_ready_o,
    output logic                                           rs2_ready_o,
    output rename_types_pkg::phys_tag_t                    new_phys_o,
    output rename_types_pkg::phys_tag_t                    old_phys_o,
    output logic                                           stall_o,
    output logic                                           fl_pop_o,
    output logic [`RN_CP_SLOTS-1:0]                        cp_capture_o,
    output rename_ctrl_pkg::cp_idx_t                       branch_slot_o,
    output rename_types_pkg::map_image_t                   map_image_o
);

    rename_types_pkg::map_image_t table_q;
    logic [`RN_PHYS_REGS-1:0]     ready_q;
    // next checkpoint slot to fill
    rename_ctrl_pkg::cp_idx_t     alloc_ptr_q;

    logic [`RN_PHYS_REGS-1:0] wb_mask;
    logic [`RN_PHYS_REGS-1:0] ready_fwd;
    logic                     needs_tag;
    logic                     accept;

    // ========================================
    // writeback forwarding
    // ========================================
    always_comb begin
        wb_mask = '0;
        for (int w = 0; w < `RN_WB_PORTS; w++) begin
            if (wb_valid_i[w]) begin
                wb_mask[wb_phys_i[w]] = 1'b1;
            end
        end
    end

    // results arriving this cycle count as ready for lookup
    assign ready_fwd = ready_q | wb_mask;

    // source lookup
    assign rs1_phys_o  = (rs1_arch_i == '0) ? '0 : table_q[rs1_arch_i];
    assign rs2_phys_o  = (rs2_arch_i == '0) ? '0 : table_q[rs2_arch_i];
    assign rs1_ready_o = (rs1_arch_i == '0) | ready_fwd[rs1_phys_o];
    assign rs2_ready_o = (rs2_arch_i == '0) | ready_fwd[rs2_phys_o];

    // destination, old tag goes to the reorder buffer
    assign new_phys_o = fl_head_tag_i;
    assign old_phys_o = table_q[disp_arch_i];

    // ========================================
    // stall and dispatch accept
    // ========================================
    assign needs_tag = disp_valid_i & ~disp_branch_i & (disp_arch_i != '0);

    // empty free list, full checkpoint ring, or a restore in progress
    assign stall_o = restore_valid_i
                   | (needs_tag & fl_empty_i)
                   | (disp_valid_i & disp_branch_i & cp_held_i[alloc_ptr_q]);

    assign accept   = disp_valid_i & ~stall_o;
    assign fl_pop_o = accept & needs_tag;

    // one-hot capture into the allocation slot
    always_comb begin
        for (int s = 0; s < `RN_CP_SLOTS; s++) begin
            cp_capture_o[s] = accept & disp_branch_i
                            & (alloc_ptr_q == rename_ctrl_pkg::cp_idx_t'(s));
        end
    end

    assign branch_slot_o = alloc_ptr_q;
    // a branch renames nothing so the live table is the checkpoint
    assign map_image_o   = table_q;

    // ========================================
    // table, ready vector and slot pointer
    // ========================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity map
            for (int a = 0; a < `RN_ARCH_REGS; a++) begin
                table_q[a] <= rename_types_pkg::phys_tag_t'(a);
            end
            ready_q     <= '1;
            alloc_ptr_q <= '0;
        end else begin
            if (restore_valid_i) begin
                // every slot is released together with the restore
                table_q     <= restore_image_i;
                alloc_ptr_q <= '0;
            end else begin
                if (fl_pop_o) begin
                    table_q[disp_arch_i] <= fl_head_tag_i;
                end
                if (accept && disp_branch_i) begin
                    alloc_ptr_q <= alloc_ptr_q + 1'b1;
                end
            end
            ready_q <= ready_q | wb_mask;
            // the later clear wins when a writeback hits the tag being handed out
            if (fl_pop_o) begin
                ready_q[fl_head_tag_i] <= 1'b0;
            end
        end
    end

endmodule

// File: rename_checker.sv
`timescale 1ns/1ps
// ======================================
// assertions bound into rename_unit
// sampled on the rising edge, off in reset
// ======================================
`include "rename_defines.svh"

module rename_checker (
    input logic                        clock,
    input logic                        reset,
    input logic                        fl_pop_i,
    input logic                        fl_empty_i,
    input logic [`RN_CP_SLOTS-1:0]     cp_capture_i,
    input logic [`RN_CP_SLOTS-1:0]     cp_held_i,
    input rename_types_pkg::phys_tag_t rs1_phys_i,
    input rename_types_pkg::phys_tag_t rs2_phys_i,
    input logic                        rs1_ready_i,
    input logic                        rs2_ready_i,
    input logic                        resolve_valid_i,
    input logic                        mispredict_i,
    input logic                        stall_i
);

    // a tag is only handed out when one exists
    a_pop_not_empty: assert property (@(posedge clock) disable iff (reset)
        fl_pop_i |-> !fl_empty_i)
        else $error("free list popped while empty");

    // a held checkpoint is never overwritten
    a_capture_free: assert property (@(posedge clock) disable iff (reset)
        (cp_capture_i & cp_held_i) == '0)
        else $error("checkpoint captured into a held slot");

    // tag 0 belongs to r0 and is never allocated so it always reads ready
    a_r0_ready: assert property (@(posedge clock) disable iff (reset)
        ((rs1_phys_i == '0) -> rs1_ready_i) && ((rs2_phys_i == '0) -> rs2_ready_i))
        else $error("r0 source looked up as not ready");

    // a mispredict with any branch held blocks dispatch in that cycle
    a_mispredict_stall: assert property (@(posedge clock) disable iff (reset)
        (resolve_valid_i && mispredict_i && (cp_held_i != '0)) |-> stall_i)
        else $error("stall low during a mispredict");

endmodule

bind rename_unit rename_checker u_checker (
    .clock           (clock),
    .reset           (reset),
    .fl_pop_i        (fl_pop),
    .fl_empty_i      (fl_empty),
    .cp_capture_i    (cp_capture),
    .cp_held_i       (cp_held),
    .rs1_phys_i      (rs1_phys_o),
    .rs2_phys_i      (rs2_phys_o),
    .rs1_ready_i     (rs1_ready_o),
    .rs2_ready_i     (rs2_ready_o),
    .resolve_valid_i (resolve_valid_i),
    .mispredict_i    (mispredict_i),
    .stall_i         (stall_o)
);

// File: rename_ctrl_pkg.sv
// ======================================
// checkpoint control types
// ======================================
`include "rename_defines.svh"

package rename_ctrl_pkg;
    typedef enum logic {
        CP_FREE = 1'b0,
        CP_HELD = 1'b1
    } cp_state_e;
    typedef logic [$clog2(`RN_CP_SLOTS)-1:0] cp_idx_t;
endpackage

// File: rename_defines.svh
// ======================================
// sizing macros for the rename stage
// RN_PHYS_REGS must be at least RN_ARCH_REGS
// RN_CP_SLOTS must be a power of two
// because the slot pointers wrap freely
// ======================================
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural and physical register counts
`define RN_ARCH_REGS 8
`define RN_PHYS_REGS 16

// branch checkpoints held at once
`define RN_CP_SLOTS 4

// result buses that can mark a tag ready
`define RN_WB_PORTS 2

`endif

// File: rename_types_pkg.sv
// ======================================
// register and tag types of the rename stage
// free pointers carry one extra wrap bit
// ======================================
`include "rename_defines.svh"

package rename_types_pkg;
    typedef logic [$clog2(`RN_ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0] phys_tag_t;
    // one tag per architectural register, r0 in the low entry
    typedef phys_tag_t [`RN_ARCH_REGS-1:0] map_image_t;
    // index bits plus wrap bit
    typedef logic [$clog2(`RN_PHYS_REGS):0] fl_ptr_t;
endpackage

// File: rename_unit.sv
`timescale 1ns/1ps
// ======================================
// rename stage top level
// all commands are single-cycle strobes
// a stalled dispatch must be held by the source
// ======================================
`include "rename_defines.svh"

module rename_unit (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           disp_valid_i,
    input  logic                                           disp_branch_i,
    input  rename_types_pkg::arch_idx_t                    disp_arch_i,
    input  rename_types_pkg::arch_idx_t                    rs1_arch_i,
    input  rename_types_pkg::arch_idx_t                    rs2_arch_i,
    input  logic [`RN_WB_PORTS-1:0]                        wb_valid_i,
    input  rename_types_pkg::phys_tag_t [`RN_WB_PORTS-1:0] wb_phys_i,
    input  logic                                           commit_valid_i,
    input  rename_types_pkg::phys_tag_t                    commit_free_phys_i,
    input  logic                                           resolve_valid_i,
    input  logic                                           mispredict_i,
    output rename_types_pkg::phys_tag_t                    rs1_phys_o,
    output rename_types_pkg::phys_tag_t                    rs2_phys_o,
    output logic                                           rs1_ready_o,
    output logic                                           rs2_ready_o,
    output rename_types_pkg::phys_tag_t                    new_phys_o,
    output rename_types_pkg::phys_tag_t                    old_phys_o,
    output logic                                           stall_o,
    output rename_ctrl_pkg::cp_idx_t                       branch_slot_o
);

    // free list
    logic                         fl_pop;
    logic                         fl_empty;
    rename_types_pkg::phys_tag_t  fl_head_tag;
    rename_types_pkg::fl_ptr_t    fl_head_ptr;

    // checkpoint fill and drain
    logic [`RN_CP_SLOTS-1:0]                        cp_capture;
    logic [`RN_CP_SLOTS-1:0]                        cp_release;
    logic [`RN_CP_SLOTS-1:0]                        cp_held;
    rename_types_pkg::map_image_t [`RN_CP_SLOTS-1:0] slot_image;
    rename_types_pkg::fl_ptr_t [`RN_CP_SLOTS-1:0]    slot_head;
    rename_types_pkg::map_image_t                   map_image;

    // restore path
    logic                         restore_valid;
    rename_types_pkg::map_image_t restore_image;
    rename_types_pkg::fl_ptr_t    restore_head;

    free_list u_free_list (
        .clock          (clock),
        .reset          (reset),
        .pop_i          (fl_pop),
        .push_i         (commit_valid_i),
        .push_tag_i     (commit_free_phys_i),
        .restore_i      (restore_valid),
        .restore_head_i (restore_head),
        .head_tag_o     (fl_head_tag),
        .head_ptr_o     (fl_head_ptr),
        .empty_o        (fl_empty)
    );

    map_table u_map_table (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid_i),
        .disp_branch_i   (disp_branch_i),
        .disp_arch_i     (disp_arch_i),
        .rs1_arch_i      (rs1_arch_i),
        .rs2_arch_i      (rs2_arch_i),
        .wb_valid_i      (wb_valid_i),
        .wb_phys_i       (wb_phys_i),
        .fl_head_tag_i   (fl_head_tag),
        .fl_empty_i      (fl_empty),
        .cp_held_i       (cp_held),
        .restore_valid_i (restore_valid),
        .restore_image_i (restore_image),
        .rs1_phys_o      (rs1_phys_o),
        .rs2_phys_o      (rs2_phys_o),
        .rs1_ready_o     (rs1_ready_o),
        .rs2_ready_o     (rs2_ready_o),
        .new_phys_o      (new_phys_o),
        .old_phys_o      (old_phys_o),
        .stall_o         (stall_o),
        .fl_pop_o        (fl_pop),
        .cp_capture_o    (cp_capture),
        .branch_slot_o   (branch_slot_o),
        .map_image_o     (map_image)
    );

    // every slot sees the live table and free head, capture picks one
    for (genvar s = 0; s < `RN_CP_SLOTS; s++) begin : g_slot
        checkpoint_slot u_slot (
            .clock     (clock),
            .reset     (reset),
            .capture_i (cp_capture[s]),
            .release_i (cp_release[s]),
            .image_i   (map_image),
            .head_i    (fl_head_ptr),
            .held_o    (cp_held[s]),
            .image_o   (slot_image[s]),
            .head_o    (slot_head[s])
        );
    end

    branch_recovery u_recovery (
        .clock           (clock),
        .reset           (reset),
        .resolve_valid_i (resolve_valid_i),
        .mispredict_i    (mispredict_i),
        .slot_held_i     (cp_held),
        .slot_image_i    (slot_image),
        .slot_head_i     (slot_head),
        .release_o       (cp_release),
        .restore_valid_o (restore_valid),
        .restore_image_o (restore_image),
        .restore_head_o  (restore_head)
    );

endmodule

// File: tb_rename_unit.sv
`timescale 1ns/1ps
// ======================================
// random testbench for the rename stage
// commits retire old tags only while no branch is held
// a stalled dispatch is presented again unchanged
// ======================================
`include "rename_defines.svh"

module tb_rename_unit;

    localparam int NUM_CYCLES = 2000;
    // per phase weights in percent, phases of 500 cycles
    localparam int BRANCH_PCT [4]  = '{15, 10, 50, 30};
    localparam int COMMIT_PCT [4]  = '{40, 8, 40, 30};
    localparam int RESOLVE_PCT [4] = '{20, 30, 6, 25};
    localparam int MISPRED_PCT [4] = '{35, 35, 35, 60};

    typedef struct packed {
        rename_types_pkg::phys_tag_t rs1_phys;
        rename_types_pkg::phys_tag_t rs2_phys;
        logic                        rs1_ready;
        logic                        rs2_ready;
        logic                        new_valid;
        rename_types_pkg::phys_tag_t new_phys;
        rename_types_pkg::phys_tag_t old_phys;
        logic                        stall;
        rename_ctrl_pkg::cp_idx_t    branch_slot;
    } expect_t;

    // model checkpoint, lengths mark where wrong-path entries start
    typedef struct packed {
        rename_types_pkg::map_image_t image;
        int                           alloc_len;
        int                           old_len;
    } checkpoint_t;

    logic clock = 1'b0;
    logic reset;

    // DUT inputs
    logic                                           disp_valid;
    logic                                           disp_branch;
    rename_types_pkg::arch_idx_t                    disp_arch;
    rename_types_pkg::arch_idx_t                    rs1_arch;
    rename_types_pkg::arch_idx_t                    rs2_arch;
    logic [`RN_WB_PORTS-1:0]                        wb_valid;
    rename_types_pkg::phys_tag_t [`RN_WB_PORTS-1:0] wb_phys;
    logic                                           commit_valid;
    rename_types_pkg::phys_tag_t                    commit_free_phys;
    logic                                           resolve_valid;
    logic                                           mispredict;

    // DUT outputs
    rename_types_pkg::phys_tag_t rs1_phys;
    rename_types_pkg::phys_tag_t rs2_phys;
    logic                        rs1_ready;
    logic                        rs2_ready;
    rename_types_pkg::phys_tag_t new_phys;
    rename_types_pkg::phys_tag_t old_phys;
    logic                        stall;
    rename_ctrl_pkg::cp_idx_t    branch_slot;

    // reference model state
    rename_types_pkg::map_image_t m_table;
    logic [`RN_PHYS_REGS-1:0]     m_ready;
    rename_types_pkg::phys_tag_t  free_q[$];
    rename_types_pkg::phys_tag_t  old_q[$];
    rename_types_pkg::phys_tag_t  alloc_log[$];
    checkpoint_t                  cp_q[$];
    rename_ctrl_pkg::cp_idx_t     m_slot;
    logic                         held_over;
    int                           cycle;
    int                           error_count;

    rename_unit uut (
        .clock              (clock),
        .reset              (reset),
        .disp_valid_i       (disp_valid),
        .disp_branch_i      (disp_branch),
        .disp_arch_i        (disp_arch),
        .rs1_arch_i         (rs1_arch),
        .rs2_arch_i         (rs2_arch),
        .wb_valid_i         (wb_valid),
        .wb_phys_i          (wb_phys),
        .commit_valid_i     (commit_valid),
        .commit_free_phys_i (commit_free_phys),
        .resolve_valid_i    (resolve_valid),
        .mispredict_i       (mispredict),
        .rs1_phys_o         (rs1_phys),
        .rs2_phys_o         (rs2_phys),
        .rs1_ready_o        (rs1_ready),
        .rs2_ready_o        (rs2_ready),
        .new_phys_o         (new_phys),
        .old_phys_o         (old_phys),
        .stall_o            (stall),
        .branch_slot_o      (branch_slot)
    );

    always #5 clock = ~clock;

    function automatic logic chance(int pct);
        return ($urandom_range(99, 0) < pct);
    endfunction

    task automatic fail_run();
        error_count = error_count + 1;
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(string name, logic [3:0] expv, logic [3:0] actv);
        assert (actv === expv) else begin
            $display("[ERROR] time %0t: %s expected %0h, actual %0h", $time, name, expv, actv);
            fail_run();
        end
    endtask

    // ========================================
    // reference model
    // ========================================
    task automatic reset_model();
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
            m_table[a] = rename_types_pkg::phys_tag_t'(a);
        end
        m_ready = '1;
        free_q.delete();
        old_q.delete();
        alloc_log.delete();
        cp_q.delete();
        // identity map leaves the upper tags free, lowest first
        for (int t = `RN_ARCH_REGS; t < `RN_PHYS_REGS; t++) begin
            free_q.push_back(rename_types_pkg::phys_tag_t'(t));
        end
        m_slot    = '0;
        held_over = 1'b0;
    endtask

    // outputs for the current inputs and model state
    function automatic expect_t expected_outputs();
        expect_t                  e;
        logic [`RN_PHYS_REGS-1:0] fwd;
        logic                     needs_tag;
        logic                     bad_resolve;
        fwd = m_ready;
        for (int w = 0; w < `RN_WB_PORTS; w++) begin
            if (wb_valid[w]) begin
                fwd[wb_phys[w]] = 1'b1;
            end
        end
        needs_tag   = disp_valid & ~disp_branch & (disp_arch != '0);
        bad_resolve = resolve_valid & mispredict & (cp_q.size() > 0);
        e.rs1_phys  = (rs1_arch == '0) ? '0 : m_table[rs1_arch];
        e.rs2_phys  = (rs2_arch == '0) ? '0 : m_table[rs2_arch];
        e.rs1_ready = (rs1_arch == '0) | fwd[e.rs1_phys];
        e.rs2_ready = (rs2_arch == '0) | fwd[e.rs2_phys];
        e.new_valid = (free_q.size() > 0);
        e.new_phys  = '0;
        if (e.new_valid) begin
            e.new_phys = free_q[0];
        end
        e.old_phys    = m_table[disp_arch];
        e.stall       = bad_resolve
                      | (needs_tag & (free_q.size() == 0))
                      | (disp_valid & disp_branch & (cp_q.size() == `RN_CP_SLOTS));
        e.branch_slot = m_slot;
        return e;
    endfunction

    // apply one clock edge of the current inputs to the model
    task automatic advance_model();
        expect_t                     e;
        checkpoint_t                 cp;
        rename_types_pkg::phys_tag_t tag;
        e         = expected_outputs();
        held_over = disp_valid & e.stall;
        for (int w = 0; w < `RN_WB_PORTS; w++) begin
            if (wb_valid[w]) begin
                m_ready[wb_phys[w]] = 1'b1;
            end
        end
        if (resolve_valid && cp_q.size() > 0) begin
            if (mispredict) begin
                cp = cp_q[0];
                // wrong-path tags return to the front in allocation order
                while (alloc_log.size() > cp.alloc_len) begin
                    free_q.push_front(alloc_log.pop_back());
                end
                while (old_q.size() > cp.old_len) begin
                    void'(old_q.pop_back());
                end
                m_table = cp.image;
                cp_q.delete();
                m_slot = '0;
            end else begin
                void'(cp_q.pop_front());
            end
        end
        if (commit_valid) begin
            free_q.push_back(commit_free_phys);
        end
        if (disp_valid && !e.stall) begin
            if (disp_branch) begin
                cp.image     = m_table;
                cp.alloc_len = alloc_log.size();
                cp.old_len   = old_q.size();
                cp_q.push_back(cp);
                m_slot = m_slot + 1'b1;
            end else if (disp_arch != '0) begin
                tag = free_q.pop_front();
                old_q.push_back(m_table[disp_arch]);
                m_table[disp_arch] = tag;
                // allocation wins over a same-cycle writeback
                m_ready[tag] = 1'b0;
                alloc_log.push_back(tag);
            end
        end
    endtask

    // ========================================
    // stimulus
    // ========================================
    task drive_next();
        int                          phase;
        rename_types_pkg::arch_idx_t pick;
        phase = cycle / 500;
        if (phase > 3) begin
            phase = 3;
        end
        if (!held_over) begin
            disp_valid  <= chance(80);
            disp_branch <= chance(BRANCH_PCT[phase]);
            disp_arch   <= rename_types_pkg::arch_idx_t'($urandom_range(7, 0));
            rs1_arch    <= rename_types_pkg::arch_idx_t'($urandom_range(7, 0));
            rs2_arch    <= rename_types_pkg::arch_idx_t'($urandom_range(7, 0));
        end
        // writebacks hit mapped tags, sometimes the tag about to be allocated
        for (int w = 0; w < `RN_WB_PORTS; w++) begin
            pick = rename_types_pkg::arch_idx_t'($urandom_range(7, 0));
            wb_valid[w] <= chance(40);
            if (chance(25) && free_q.size() > 0) begin
                wb_phys[w] <= free_q[0];
            end else begin
                wb_phys[w] <= m_table[pick];
            end
        end
        if (cp_q.size() == 0 && old_q.size() > 0 && chance(COMMIT_PCT[phase])) begin
            commit_valid     <= 1'b1;
            commit_free_phys <= old_q.pop_front();
        end else begin
            commit_valid <= 1'b0;
        end
        resolve_valid <= (cp_q.size() > 0) && chance(RESOLVE_PCT[phase]);
        mispredict    <= chance(MISPRED_PCT[phase]);
    endtask

    initial begin
        void'($urandom(90602));
        reset            = 1'b1;
        disp_valid       = 1'b0;
        disp_branch      = 1'b0;
        disp_arch        = '0;
        rs1_arch         = '0;
        rs2_arch         = '0;
        wb_valid         = '0;
        wb_phys          = '0;
        commit_valid     = 1'b0;
        commit_free_phys = '0;
        resolve_valid    = 1'b0;
        mispredict       = 1'b0;
        error_count      = 0;
        cycle            = 0;
        reset_model();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        drive_next();
        for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge clock);
            advance_model();
            drive_next();
        end
        // let the last compare finish first
        @(negedge clock);
        #1;
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // ========================================
    // compare and watchdog
    // ========================================
    always @(negedge clock) begin : compare_outputs
        expect_t e;
        if (!reset) begin
            e = expected_outputs();
            check_value("rs1_phys_o", e.rs1_phys, rs1_phys);
            check_value("rs2_phys_o", e.rs2_phys, rs2_phys);
            check_value("rs1_ready_o", 4'(e.rs1_ready), 4'(rs1_ready));
            check_value("rs2_ready_o", 4'(e.rs2_ready), 4'(rs2_ready));
            // head tag is undefined on an empty free list
            if (e.new_valid) begin
                check_value("new_phys_o", e.new_phys, new_phys);
            end
            check_value("old_phys_o", e.old_phys, old_phys);
            check_value("stall_o", 4'(e.stall), 4'(stall));
            check_value("branch_slot_o", 4'(e.branch_slot), 4'(branch_slot));
        end
    end

    initial begin
        #((NUM_CYCLES + 100) * 10);
        $display("watchdog expired before the stimulus loop finished");
        fail_run();
    end

endmodule
